// ==== Makefile ====
TOP := tb_dma_cluster_frontend

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir

run: build
	out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '*** PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== flist.f ====
+incdir+include
rtl/dma_pkg.sv
rtl/dma_spill_register.sv
rtl/dma_split_midend.sv
rtl/dma_distributed_midend.sv
rtl/dma_cluster_frontend.sv
sim/tb_dma_cluster_frontend.sv

// ==== include/dma_params.svh ====
/* Sizing of the cluster DMA front end. The TCDM base must be aligned to a full row
   and the completion FIFO depth must be a power of two */
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Groups sharing the interleaved TCDM
`define DMA_NUM_GROUPS 4

// Bytes of one group's slice within a row
`define DMA_GROUP_BYTES 16

// TCDM window
`define DMA_TCDM_BASE 32'h0001_0000
`define DMA_TCDM_SIZE 32'h0000_4000

// Entries of each completion bookkeeping FIFO
`define DMA_FIFO_DEPTH 8

`endif

// ==== rtl/dma_cluster_frontend.sv ====
/* Cluster DMA front end. Splits bursts per TCDM row and group slice and gives one
   done pulse per burst, in burst order. Groups must finish their own pieces in order */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_cluster_frontend
  import dma_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Burst request
  input  dma_req_t                       dma_req_i,
  input  logic                           dma_valid_i,
  output logic                           dma_ready_o,
  // Group ports
  output dma_req_t [`DMA_NUM_GROUPS-1:0] group_req_o,
  output logic     [`DMA_NUM_GROUPS-1:0] group_valid_o,
  input  logic     [`DMA_NUM_GROUPS-1:0] group_ready_i,
  input  logic     [`DMA_NUM_GROUPS-1:0] group_done_i,
  // Status
  output logic                           dma_done_o,
  output logic                           busy_o
);

  dma_req_t cut_req;
  logic     cut_valid, cut_ready;

  dma_req_t row_req;
  logic     row_valid, row_ready, row_done;
  logic     burst_done;

  dma_req_t [`DMA_NUM_GROUPS-1:0] grp_req;
  logic     [`DMA_NUM_GROUPS-1:0] grp_valid, grp_ready;

  logic [7:0] outstanding_q;

  dma_spill_register i_in_cut (
    .clk_i  (clk_i      ),
    .rst_n_i(rst_n_i    ),
    .data_i (dma_req_i  ),
    .valid_i(dma_valid_i),
    .ready_o(dma_ready_o),
    .data_o (cut_req    ),
    .valid_o(cut_valid  ),
    .ready_i(cut_ready  )
  );

  dma_split_midend i_split (
    .clk_i        (clk_i     ),
    .rst_n_i      (rst_n_i   ),
    .burst_i      (cut_req   ),
    .burst_valid_i(cut_valid ),
    .burst_ready_o(cut_ready ),
    .row_o        (row_req   ),
    .row_valid_o  (row_valid ),
    .row_ready_i  (row_ready ),
    .row_done_i   (row_done  ),
    .burst_done_o (burst_done)
  );

  dma_distributed_midend i_dist (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .row_i        (row_req     ),
    .row_valid_i  (row_valid   ),
    .row_ready_o  (row_ready   ),
    .group_req_o  (grp_req     ),
    .group_valid_o(grp_valid   ),
    .group_ready_i(grp_ready   ),
    .group_done_i (group_done_i),
    .row_done_o   (row_done    )
  );

  for (genvar g = 0; g < `DMA_NUM_GROUPS; g++) begin : gen_group_cut
    dma_spill_register i_group_cut (
      .clk_i  (clk_i           ),
      .rst_n_i(rst_n_i         ),
      .data_i (grp_req[g]      ),
      .valid_i(grp_valid[g]    ),
      .ready_o(grp_ready[g]    ),
      .data_o (group_req_o[g]  ),
      .valid_o(group_valid_o[g]),
      .ready_i(group_ready_i[g])
    );
  end : gen_group_cut

  // Bursts accepted but not yet reported done
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dma_done_o    <= 1'b0;
      outstanding_q <= '0;
    end else begin
      dma_done_o    <= burst_done;
      outstanding_q <= outstanding_q + 8'(dma_valid_i && dma_ready_o) - 8'(burst_done);
    end
  end

  assign busy_o = outstanding_q != '0;

  a_done_has_burst: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    burst_done |-> outstanding_q != '0
  );

endmodule

// ==== rtl/dma_distributed_midend.sv ====
/* Cuts row pieces into 16-byte group slices and routes each to its owner group.
   Expects pieces that stay within one row. Out-of-window pieces go whole to group 0 */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_distributed_midend
  import dma_pkg::*;
(
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  dma_req_t                       row_i,
  input  logic                           row_valid_i,
  output logic                           row_ready_o,
  output dma_req_t [`DMA_NUM_GROUPS-1:0] group_req_o,
  output logic     [`DMA_NUM_GROUPS-1:0] group_valid_o,
  input  logic     [`DMA_NUM_GROUPS-1:0] group_ready_i,
  input  logic     [`DMA_NUM_GROUPS-1:0] group_done_i,
  output logic                           row_done_o
);

  localparam int unsigned NG         = `DMA_NUM_GROUPS;
  localparam int unsigned SLICE_BITS = $clog2(`DMA_GROUP_BYTES);
  localparam int unsigned GID_W      = $clog2(NG);
  localparam int unsigned PTR_W      = $clog2(`DMA_FIFO_DEPTH);
  localparam int unsigned CREDIT_W   = PTR_W + 1;

  function automatic logic [GID_W-1:0] slice_gid(logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - `DMA_TCDM_BASE;
    return offset[SLICE_BITS +: GID_W];
  endfunction

  dist_state_e      state_q;
  dma_req_t         cur_q;
  logic             in_win_q;
  logic [15:0]      slice_room, piece_len;
  logic [GID_W-1:0] tgt_gid, first_gid, last_gid;
  dma_req_t         piece;
  logic             row_hs, piece_hs, last_piece;
  group_mask_t      row_mask;

  group_mask_t                     mask_mem [`DMA_FIFO_DEPTH];
  logic [PTR_W-1:0]                wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]                  fill_q;
  logic                            mask_full, mask_empty;
  group_mask_t                     head_mask, has_credit;
  logic [NG-1:0][CREDIT_W-1:0]     credit_q;

  assign mask_full  = fill_q == (PTR_W+1)'(`DMA_FIFO_DEPTH);
  assign mask_empty = fill_q == '0;

  assign row_ready_o = (state_q == DST_IDLE) && !mask_full;
  assign row_hs      = row_valid_i && row_ready_o;

  // Groups touched by the incoming row piece
  always_comb begin
    first_gid = slice_gid(row_i.dst_addr);
    last_gid  = slice_gid(row_i.dst_addr + 32'(row_i.num_bytes) - 32'd1);
    row_mask  = '0;
    if (in_tcdm(row_i.dst_addr)) begin
      for (int g = 0; g < NG; g++) begin
        if ((GID_W'(g) >= first_gid) && (GID_W'(g) <= last_gid)) row_mask[g] = 1'b1;
      end
    end else begin
      row_mask[0] = 1'b1;
    end
  end

  always_comb begin
    slice_room = 16'(`DMA_GROUP_BYTES) - 16'(cur_q.dst_addr[SLICE_BITS-1:0]);
    if (in_win_q && (cur_q.num_bytes > slice_room)) begin
      piece_len = slice_room;
    end else begin
      piece_len = cur_q.num_bytes;
    end
  end

  assign tgt_gid    = in_win_q ? slice_gid(cur_q.dst_addr) : '0;
  assign last_piece = piece_len == cur_q.num_bytes;
  assign piece      = '{src_addr: cur_q.src_addr, dst_addr: cur_q.dst_addr,
                        num_bytes: piece_len};
  assign piece_hs   = (state_q == DST_ISSUE) && group_ready_i[tgt_gid];

  // Same data to all ports, valid only towards the owner
  always_comb begin
    group_valid_o = '0;
    for (int g = 0; g < NG; g++) begin
      group_req_o[g] = piece;
    end
    if (state_q == DST_ISSUE) group_valid_o[tgt_gid] = 1'b1;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= DST_IDLE;
    end else begin
      case (state_q)
        DST_IDLE:  if (row_hs) state_q <= DST_ISSUE;
        DST_ISSUE: if (piece_hs && last_piece) state_q <= DST_IDLE;
        default:   state_q <= DST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (row_hs) begin
      cur_q    <= row_i;
      in_win_q <= in_tcdm(row_i.dst_addr);
    end else if (piece_hs) begin
      cur_q.src_addr  <= cur_q.src_addr + 32'(piece_len);
      cur_q.dst_addr  <= cur_q.dst_addr + 32'(piece_len);
      cur_q.num_bytes <= cur_q.num_bytes - piece_len;
    end
    if (row_hs) mask_mem[wr_ptr_q] <= row_mask;
  end

  // Oldest row piece done once every group it used has a credit
  assign head_mask = mask_mem[rd_ptr_q];
  always_comb begin
    for (int g = 0; g < NG; g++) begin
      has_credit[g] = credit_q[g] != '0;
    end
  end
  assign row_done_o = !mask_empty && (&(has_credit | ~head_mask));

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
      credit_q <= '0;
    end else begin
      if (row_hs) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (row_done_o) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      fill_q <= fill_q + (PTR_W+1)'(row_hs) - (PTR_W+1)'(row_done_o);
      for (int g = 0; g < NG; g++) begin
        credit_q[g] <= credit_q[g] + CREDIT_W'(group_done_i[g])
                     - CREDIT_W'(row_done_o && head_mask[g]);
      end
    end
  end

  for (genvar g = 0; g < NG; g++) begin : gen_slice_check
    a_one_slice: assert property (
      @(posedge clk_i) disable iff (!rst_n_i)
      group_valid_o[g] && in_tcdm(group_req_o[g].dst_addr) |->
        (17'(group_req_o[g].dst_addr[SLICE_BITS-1:0]) + 17'(group_req_o[g].num_bytes))
          <= 17'(`DMA_GROUP_BYTES)
    );
  end : gen_slice_check

endmodule

// ==== rtl/dma_pkg.sv ====
/* Shared types of the cluster DMA front end. Bursts, row pieces and group pieces
   all use one request layout */
`include "dma_params.svh"

package dma_pkg;

  // Bursts, row pieces and group pieces
  typedef struct packed {
    logic [31:0] src_addr;
    logic [31:0] dst_addr;
    logic [15:0] num_bytes;
  } dma_req_t;

  // Groups that received a piece of one row piece
  typedef logic [`DMA_NUM_GROUPS-1:0] group_mask_t;

  typedef enum logic {
    SPL_IDLE,
    SPL_SPLIT
  } split_state_e;

  typedef enum logic {
    DST_IDLE,
    DST_ISSUE
  } dist_state_e;

  // Destination decides splitting, only the start address is looked at
  function automatic logic in_tcdm(logic [31:0] addr);
    return (addr >= `DMA_TCDM_BASE) && (addr < (`DMA_TCDM_BASE + `DMA_TCDM_SIZE));
  endfunction

endpackage

// ==== rtl/dma_spill_register.sv ====
/* Two-entry valid/ready cut. Ready and data are both registered, so no
   combinational path crosses it, and it sustains one transfer per cycle */
`timescale 1ns/1ps

module dma_spill_register
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_req_t data_i,
  input  logic     valid_i,
  output logic     ready_o,
  output dma_req_t data_o,
  output logic     valid_o,
  input  logic     ready_i
);

  dma_req_t a_data_q, b_data_q;
  logic     a_full_q, b_full_q;
  logic     a_fill, a_drain;
  logic     b_fill, b_drain;

  // A takes new data, B catches what A cannot hand on
  assign a_fill  = valid_i & ready_o;
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B always holds the older entry
  assign ready_o = ~a_full_q | ~b_full_q;
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

  a_stable_out: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  );

endmodule

// ==== rtl/dma_split_midend.sv ====
/* Cuts bursts at 64-byte destination rows inside the TCDM window; others pass whole.
   Zero-length bursts are not allowed. Row completions must arrive in issue order */
`timescale 1ns/1ps
`include "dma_params.svh"

module dma_split_midend
  import dma_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  dma_req_t burst_i,
  input  logic     burst_valid_i,
  output logic     burst_ready_o,
  output dma_req_t row_o,
  output logic     row_valid_o,
  input  logic     row_ready_i,
  input  logic     row_done_i,
  output logic     burst_done_o
);

  localparam int unsigned ROW_BYTES = `DMA_NUM_GROUPS * `DMA_GROUP_BYTES;
  localparam int unsigned ROW_BITS  = $clog2(ROW_BYTES);
  localparam int unsigned PTR_W     = $clog2(`DMA_FIFO_DEPTH);
  localparam int unsigned CNT_W     = 17 - ROW_BITS;

  split_state_e     state_q;
  dma_req_t         cur_q;
  logic             in_win_q;
  logic [15:0]      row_room, piece_len;
  logic             last_piece, burst_hs, row_hs;
  logic [16:0]      span;
  logic [CNT_W-1:0] num_pieces;

  logic [CNT_W-1:0] cnt_mem [`DMA_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [PTR_W:0]   fill_q;
  logic             fifo_full, fifo_empty;
  logic [CNT_W-1:0] done_cnt_q;

  assign fifo_full  = fill_q == (PTR_W+1)'(`DMA_FIFO_DEPTH);
  assign fifo_empty = fill_q == '0;

  assign burst_ready_o = (state_q == SPL_IDLE) && !fifo_full;
  assign burst_hs      = burst_valid_i && burst_ready_o;
  assign row_valid_o   = state_q == SPL_SPLIT;
  assign row_hs        = row_valid_o && row_ready_i;

  // Row pieces a burst will produce, counted at acceptance
  assign span       = 17'(burst_i.dst_addr[ROW_BITS-1:0]) + 17'(burst_i.num_bytes)
                    + 17'(ROW_BYTES - 1);
  assign num_pieces = in_tcdm(burst_i.dst_addr) ? span[16:ROW_BITS] : CNT_W'(1);

  always_comb begin
    row_room = 16'(ROW_BYTES) - 16'(cur_q.dst_addr[ROW_BITS-1:0]);
    if (in_win_q && (cur_q.num_bytes > row_room)) begin
      piece_len = row_room;
    end else begin
      piece_len = cur_q.num_bytes;
    end
  end

  assign last_piece = piece_len == cur_q.num_bytes;
  assign row_o      = '{src_addr: cur_q.src_addr, dst_addr: cur_q.dst_addr,
                        num_bytes: piece_len};

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= SPL_IDLE;
    end else begin
      case (state_q)
        SPL_IDLE:  if (burst_hs) state_q <= SPL_SPLIT;
        SPL_SPLIT: if (row_hs && last_piece) state_q <= SPL_IDLE;
        default:   state_q <= SPL_IDLE;
      endcase
    end
  end

  // Walk the burst one row at a time
  always_ff @(posedge clk_i) begin
    if (burst_hs) begin
      cur_q    <= burst_i;
      in_win_q <= in_tcdm(burst_i.dst_addr);
    end else if (row_hs) begin
      cur_q.src_addr  <= cur_q.src_addr + 32'(piece_len);
      cur_q.dst_addr  <= cur_q.dst_addr + 32'(piece_len);
      cur_q.num_bytes <= cur_q.num_bytes - piece_len;
    end
  end

  // Oldest burst completes once all its row pieces reported done
  assign burst_done_o = row_done_i && !fifo_empty &&
                        ((done_cnt_q + CNT_W'(1)) == cnt_mem[rd_ptr_q]);

  always_ff @(posedge clk_i) begin
    if (burst_hs) cnt_mem[wr_ptr_q] <= num_pieces;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      fill_q     <= '0;
      done_cnt_q <= '0;
    end else begin
      if (burst_hs) wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      if (burst_done_o) rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      fill_q <= fill_q + (PTR_W+1)'(burst_hs) - (PTR_W+1)'(burst_done_o);
      if (burst_done_o) begin
        done_cnt_q <= '0;
      end else if (row_done_i) begin
        done_cnt_q <= done_cnt_q + CNT_W'(1);
      end
    end
  end

  a_no_row_cross: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    row_valid_o && in_tcdm(row_o.dst_addr) |->
      (17'(row_o.dst_addr[ROW_BITS-1:0]) + 17'(row_o.num_bytes)) <= 17'(ROW_BYTES)
  );

  a_nonzero_burst: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    burst_hs |-> burst_i.num_bytes != '0
  );

endmodule

// ==== sim/dma_stim.txt ====
# T name starts a test. B src dst bytes is a burst (hex); bursts of a test go back to back
# P group src dst bytes is an expected piece of the burst above (group decimal, rest hex)
T single_slice
B 00002000 00010024 0008
P 2 00002000 00010024 0008
T multi_row
B 00003010 00010138 0090
P 3 00003010 00010138 0008
P 0 00003018 00010140 0010
P 1 00003028 00010150 0010
P 2 00003038 00010160 0010
P 3 00003048 00010170 0010
P 0 00003058 00010180 0010
P 1 00003068 00010190 0010
P 2 00003078 000101a0 0010
P 3 00003088 000101b0 0010
P 0 00003098 000101c0 0008
T outside_tcdm
B 00004000 00020000 0100
P 0 00004000 00020000 0100
T backpressure
B 00005003 00010205 0075
P 0 00005003 00010205 000b
P 1 0000500e 00010210 0010
P 2 0000501e 00010220 0010
P 3 0000502e 00010230 0010
P 0 0000503e 00010240 0010
P 1 0000504e 00010250 0010
P 2 0000505e 00010260 0010
P 3 0000506e 00010270 000a
T back_to_back
B 00006000 00010010 0020
P 1 00006000 00010010 0010
P 2 00006010 00010020 0010
B 00006100 00030000 0040
P 0 00006100 00030000 0040
B 00006200 00010034 001c
P 3 00006200 00010034 000c
P 0 0000620c 00010040 0010
B 00006300 000100f8 0010
P 3 00006300 000100f8 0008
P 0 00006308 00010100 0008
B 00006400 00010064 0004
P 2 00006400 00010064 0004

// ==== sim/tb_dma_cluster_frontend.sv ====
/* Testbench acting as the four groups. Reads sim/dma_stim.txt, so run it from the project
   root. Groups stall and complete at random but keep their own order */
`timescale 1ns/1ps
`include "dma_params.svh"

module tb_dma_cluster_frontend
  import dma_pkg::*;
();

  localparam int NG    = `DMA_NUM_GROUPS;
  localparam int LIMIT = 2000;
  localparam int MAXN  = 64;

  typedef struct packed {
    int       burst;
    dma_req_t req;
  } exp_piece_t;

  logic              clk_i, rst_n_i;
  dma_req_t          dma_req_i;
  logic              dma_valid_i, dma_ready_o;
  dma_req_t [NG-1:0] group_req_o;
  logic [NG-1:0]     group_valid_o, group_ready_i, group_done_i;
  logic              dma_done_o, busy_o;

  // Parsed stimulus
  logic [8*16-1:0] test_name [MAXN];
  int              test_first [MAXN];
  int              test_cnt [MAXN];
  dma_req_t        burst_req [MAXN];
  int              burst_first [MAXN];
  int              burst_pieces [MAXN];
  int              piece_grp [4*MAXN];
  dma_req_t        piece_req [4*MAXN];
  int              num_tests, num_bursts, num_pieces;

  // Group models and scoreboard
  exp_piece_t  exp_q [NG][$];
  int          done_at_q [NG][$];
  int          done_burst_q [NG][$];
  int          last_done [NG];
  int          remaining [MAXN];
  int          fin_cyc [MAXN];
  int          got_bytes [MAXN];
  int          sent, done_ptr, cycle, errors, tests_ok, tests_bad;
  logic        timed_out;
  logic [31:0] rng;

  dma_cluster_frontend dut (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .dma_req_i    (dma_req_i    ),
    .dma_valid_i  (dma_valid_i  ),
    .dma_ready_o  (dma_ready_o  ),
    .group_req_o  (group_req_o  ),
    .group_valid_o(group_valid_o),
    .group_ready_i(group_ready_i),
    .group_done_i (group_done_i ),
    .dma_done_o   (dma_done_o   ),
    .busy_o       (busy_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic load_stim();
    int               fd, code, f_grp;
    logic [7:0]       tag;
    logic [31:0]      f_src, f_dst, f_len;
    logic [8*16-1:0]  f_name;
    logic [8*200-1:0] skip_line;
    fd = $fopen("sim/dma_stim.txt", "r");
    if (fd == 0) begin
      $display("Stimulus file sim/dma_stim.txt could not be opened");
      errors++;
      return;
    end
    code = $fscanf(fd, " %c", tag);
    while (code == 1) begin
      case (tag)
        "#": code = $fgets(skip_line, fd);
        "T": begin
          code = $fscanf(fd, "%s", f_name);
          test_name[num_tests]  = f_name;
          test_first[num_tests] = num_bursts;
          test_cnt[num_tests]   = 0;
          num_tests++;
        end
        "B": begin
          code = $fscanf(fd, "%h %h %h", f_src, f_dst, f_len);
          burst_req[num_bursts]    = '{src_addr: f_src, dst_addr: f_dst, num_bytes: f_len[15:0]};
          burst_first[num_bursts]  = num_pieces;
          burst_pieces[num_bursts] = 0;
          test_cnt[num_tests-1]++;
          num_bursts++;
        end
        "P": begin
          code = $fscanf(fd, "%d %h %h %h", f_grp, f_src, f_dst, f_len);
          piece_grp[num_pieces] = f_grp;
          piece_req[num_pieces] = '{src_addr: f_src, dst_addr: f_dst, num_bytes: f_len[15:0]};
          burst_pieces[num_bursts-1]++;
          num_pieces++;
        end
        default: begin
          $display("Stimulus file holds a line of unknown type");
          errors++;
        end
      endcase
      code = $fscanf(fd, " %c", tag);
    end
    $fclose(fd);
  endtask

  // Ready, piece checks and in-order done pulses of every group
  task automatic serve_groups();
    exp_piece_t e;
    int         due;
    for (int g = 0; g < NG; g++) begin
      group_done_i[g] = 1'b0;
      if ((done_at_q[g].size() != 0) && (done_at_q[g][0] == cycle)) begin
        due = done_at_q[g].pop_front();
        e.burst = done_burst_q[g].pop_front();
        group_done_i[g] = 1'b1;
        if (e.burst >= 0) begin
          remaining[e.burst]--;
          if (remaining[e.burst] == 0) fin_cyc[e.burst] = cycle;
        end
      end
      rng = xorshift32(rng);
      group_ready_i[g] = rng[1:0] != 2'b00;
      if (group_valid_o[g] && group_ready_i[g]) begin
        assert (exp_q[g].size() != 0) else begin
          errors++;
          $display("Fail %0t: group %0d got dst %h with no piece expected", $time, g,
                   group_req_o[g].dst_addr);
        end
        e.burst = -1;
        if (exp_q[g].size() != 0) begin
          e = exp_q[g].pop_front();
          assert (group_req_o[g] == e.req) else begin
            errors++;
            $display("Fail %0t: group %0d got %h %h %h, expected %h %h %h", $time, g,
                     group_req_o[g].src_addr, group_req_o[g].dst_addr,
                     group_req_o[g].num_bytes, e.req.src_addr, e.req.dst_addr,
                     e.req.num_bytes);
          end
          got_bytes[e.burst] += int'(group_req_o[g].num_bytes);
        end
        due = cycle + 1 + int'(rng[4:2]);
        if (due <= last_done[g]) due = last_done[g] + 1;
        last_done[g] = due;
        done_at_q[g].push_back(due);
        done_burst_q[g].push_back(e.burst);
      end
    end
  endtask

  // Done pulses must follow burst order and the last piece done
  task automatic watch_done();
    if (dma_done_o) begin
      assert (done_ptr < sent) else begin
        errors++;
        $display("Fail %0t: done pulse with no burst outstanding", $time);
      end
      if (done_ptr < sent) begin
        assert ((remaining[done_ptr] == 0) && (cycle >= fin_cyc[done_ptr] + 2)) else begin
          errors++;
          $display("Fail %0t: done for burst %0d before all its pieces finished", $time,
                   done_ptr);
        end
        done_ptr++;
      end
    end
  endtask

  task automatic tick();
    @(negedge clk_i);
    cycle++;
    serve_groups();
    watch_done();
  endtask

  task automatic send_burst(int b);
    int waited;
    waited      = 0;
    dma_req_i   = burst_req[b];
    dma_valid_i = 1'b1;
    while (!dma_ready_o && (waited < LIMIT)) begin
      tick();
      waited++;
    end
    if (!dma_ready_o) begin
      $display("Timeout: burst %0d was not accepted within %0d cycles", b, LIMIT);
      errors++;
      timed_out   = 1'b1;
      dma_valid_i = 1'b0;
    end else begin
      tick();
      sent++;
      dma_valid_i = 1'b0;
      assert (busy_o) else begin
        errors++;
        $display("Fail %0t: busy_o low with burst %0d outstanding", $time, b);
      end
    end
  endtask

  task automatic report_test(logic [8*16-1:0] name, int errs_before);
    if (errors == errs_before) begin
      tests_ok++;
      $display("test %0s: ok", name);
    end else begin
      tests_bad++;
      $display("test %0s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic run_test(int t);
    int         errs_before, waited;
    logic       pending;
    exp_piece_t e;
    errs_before = errors;
    for (int b = test_first[t]; b < test_first[t] + test_cnt[t]; b++) begin
      remaining[b] = burst_pieces[b];
      got_bytes[b] = 0;
      for (int p = burst_first[b]; p < burst_first[b] + burst_pieces[b]; p++) begin
        e.burst = b;
        e.req   = piece_req[p];
        exp_q[piece_grp[p]].push_back(e);
      end
    end
    for (int b = test_first[t]; b < test_first[t] + test_cnt[t]; b++) begin
      if (!timed_out) send_burst(b);
    end
    waited  = 0;
    pending = 1'b1;
    while (pending && !timed_out && (waited < LIMIT)) begin
      tick();
      waited++;
      // Busy until the done pulse of the last accepted burst
      assert (busy_o == (done_ptr < sent)) else begin
        errors++;
        $display("Fail %0t: busy_o %b with %0d bursts outstanding", $time, busy_o,
                 sent - done_ptr);
      end
      pending = busy_o || (done_ptr < sent);
      for (int g = 0; g < NG; g++) begin
        pending = pending || (exp_q[g].size() != 0) || (done_at_q[g].size() != 0);
      end
    end
    if (pending && !timed_out) begin
      $display("Timeout: test %0s did not finish within %0d cycles", test_name[t], LIMIT);
      errors++;
      timed_out = 1'b1;
    end
    // Idle gap catches stray done pulses
    for (int i = 0; i < 4; i++) tick();
    for (int g = 0; g < NG; g++) begin
      assert (exp_q[g].size() == 0) else begin
        errors++;
        $display("Fail %0t: group %0d still expects %0d pieces", $time, g, exp_q[g].size());
      end
    end
    for (int b = test_first[t]; b < test_first[t] + test_cnt[t]; b++) begin
      assert (got_bytes[b] == int'(burst_req[b].num_bytes)) else begin
        errors++;
        $display("Fail %0t: burst %0d pieces sum to %0d bytes", $time, b, got_bytes[b]);
      end
    end
    assert (!busy_o) else begin
      errors++;
      $display("Fail %0t: busy_o high after all bursts completed", $time);
    end
    report_test(test_name[t], errs_before);
  endtask

  initial begin
    int errs_before;
    rst_n_i       = 1'b0;
    dma_req_i     = '0;
    dma_valid_i   = 1'b0;
    group_ready_i = '0;
    group_done_i  = '0;
    rng           = 32'h9a378004;
    {num_tests, num_bursts, num_pieces} = '0;
    {sent, done_ptr, cycle, errors, tests_ok, tests_bad} = '0;
    timed_out = 1'b0;
    for (int g = 0; g < NG; g++) last_done[g] = 0;
    load_stim();
    for (int i = 0; i < 2; i++) tick();
    rst_n_i     = 1'b1;
    errs_before = errors;
    tick();
    assert ((group_valid_o == '0) && !dma_done_o && !busy_o && dma_ready_o) else begin
      errors++;
      $display("Fail %0t: outputs after reset valid %b done %b busy %b ready %b", $time,
               group_valid_o, dma_done_o, busy_o, dma_ready_o);
    end
    report_test("reset", errs_before);
    for (int t = 0; (t < num_tests) && !timed_out; t++) run_test(t);
    $display("tests passed %0d, failed %0d", tests_ok, tests_bad);
    if ((tests_bad == 0) && (errors == 0) && (num_tests > 0)) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule
